// File: files.f
sd_cmd_pkg.sv
sd_crc7.sv
sd_clk_div.sv
cmd_sequencer.sv
cmd_tx.sv
resp_rx.sv
sd_cmd_path.sv
sd_card_model.sv
tb_sd_cmd_path.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --timing --assert
TOP       := tb_sd_cmd_path
FILELIST  := files.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb_sd_cmd_path.sv
module tb_sd_cmd_path
    import sd_cmd_pkg::*;
();

    localparam int CMD_COUNT      = 32;
    localparam int TIMEOUT_CYCLES = (CMD_COUNT + 8)
                                  * (CMD_FRAME_LEN + RESP_TIMEOUT + RESP_LONG_LEN + 16)
                                  * SD_CLK_DIV;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     cmd_start;
    logic [5:0]               cmd_index;
    logic [31:0]              cmd_arg;
    logic [1:0]               resp_type;
    logic                     index_check_en;
    logic                     crc_check_en;
    logic                     cmd_i;
    logic                     sd_clk;
    logic                     cmd_o;
    logic                     cmd_oe;
    logic                     cmd_busy;
    logic                     cmd_done;
    logic                     resp_valid;
    logic                     timeout_err;
    logic                     crc_err;
    logic                     index_err;
    logic [RESP_DATA_W-1:0]   resp_data;
    logic                     silent;
    int                       reply_delay;
    int                       reply_len;
    logic [RESP_LONG_LEN-1:0] reply_frame;
    int                       frame_count;
    logic [47:0]              last_frame;
    logic [31:0]              lfsr_q   = 32'h1b27_a8d8;
    int                       cycles   = 0;
    int                       dones    = 0;
    int                       accepted = 0;

    always #50 clk = ~clk;

    sd_cmd_path DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_start      (cmd_start),
        .cmd_index      (cmd_index),
        .cmd_arg        (cmd_arg),
        .resp_type      (resp_type),
        .index_check_en (index_check_en),
        .crc_check_en   (crc_check_en),
        .cmd_i          (cmd_i),
        .sd_clk         (sd_clk),
        .cmd_o          (cmd_o),
        .cmd_oe         (cmd_oe),
        .cmd_busy       (cmd_busy),
        .cmd_done       (cmd_done),
        .resp_valid     (resp_valid),
        .timeout_err    (timeout_err),
        .crc_err        (crc_err),
        .index_err      (index_err),
        .resp_data      (resp_data)
    );

    sd_card_model u_card (
        .sd_clk      (sd_clk),
        .cmd_o       (cmd_o),
        .cmd_oe      (cmd_oe),
        .silent      (silent),
        .reply_delay (reply_delay),
        .reply_len   (reply_len),
        .reply_frame (reply_frame),
        .cmd_i       (cmd_i),
        .frame_count (frame_count),
        .last_frame  (last_frame)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [119:0] expected,
                               input logic [119:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("FAILED %s: expected %0h, actual %0h",
                                     test, expected, actual));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [119:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[118:0], lfsr_q[0]};   // One step per bit
        end
    endtask

    // x^7 + x^3 + 1 over the low nbits of data MSB first
    function automatic logic [6:0] crc7(input logic [119:0] data, input int nbits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = nbits - 1; i >= 0; i--) begin
            fb = data[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && cmd_done) begin
            dones <= dones + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the commands did not complete within the cycle limit");
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) cmd_done |-> !cmd_busy && $past(cmd_busy))
        else abort_run("cmd_done pulsed without cmd_busy falling in the same cycle");
    assert property (@(posedge clk) disable iff (!rst_n) cmd_oe |-> cmd_busy)
        else abort_run("cmd_oe was high while no command was in progress");
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sd_clk) |-> ##(SD_CLK_DIV / 2) $fell(sd_clk) ##(SD_CLK_DIV / 2) $rose(sd_clk))
        else abort_run("sd_clk did not toggle every half bit period");
    assert property (@(posedge clk) disable iff (!rst_n) $changed(cmd_o) |-> !sd_clk)
        else abort_run("cmd_o changed while sd_clk was high");

    // k selects type in bits 1:0, fault in 3:2, both check enables in bit 4
    task automatic run_cmd(input int k);
        logic [119:0] rnd;
        logic [119:0] data;
        logic [5:0]   idx;
        logic [31:0]  arg;
        logic [1:0]   rtype;
        logic [1:0]   fault;   // Clean, bad CRC, wrong index, silent
        logic         en;
        logic         answered;
        logic [39:0]  head;
        logic [6:0]   crc;
        string        name;
        rtype    = k[1:0];
        fault    = k[3:2];
        en       = k[4];
        name     = $sformatf("cmd %0d type %0d fault %0d en %0d", k, rtype, fault, en);
        answered = (rtype != RESP_NONE) && (fault != 2'd3);
        take_bits(6, rnd);
        idx = rnd[5:0];
        take_bits(32, rnd);
        arg = rnd[31:0];
        take_bits(RESP_DATA_W, data);
        take_bits(3, rnd);
        if (rtype == RESP_R2) begin
            crc         = crc7(data, RESP_DATA_W) ^ {6'd0, fault == 2'd1};
            reply_frame = {8'h3f, data, crc, 1'b1};
            reply_len   = RESP_LONG_LEN;
        end else begin
            head        = {2'b00, (fault == 2'd2) ? idx ^ 6'h2a : idx, arg};
            crc         = crc7(120'(head), 40) ^ {6'd0, fault == 2'd1};
            reply_frame = {head, crc, 1'b1, 88'd0};
            reply_len   = RESP_SHORT_LEN;
        end
        silent      = !answered;
        reply_delay = 2 + int'(rnd[2:0]) % 7;
        @(negedge clk);
        cmd_index      = idx;
        cmd_arg        = arg;
        resp_type      = rtype;
        index_check_en = en;
        crc_check_en   = en;
        cmd_start      = 1'b1;
        @(negedge clk);
        cmd_start = 1'b0;
        accepted++;
        assert (cmd_busy === 1'b1)
            else abort_run($sformatf("%s: cmd_busy did not rise after cmd_start", name));
        check_value({name, " cleared flags"}, 120'd0,
                    120'({resp_valid, timeout_err, crc_err, index_err}));
        check_value({name, " cleared data"}, 120'd0, resp_data);
        repeat (4) @(negedge clk);
        cmd_start = 1'b1;   // Lands while busy
        @(negedge clk);
        cmd_start = 1'b0;
        while (cmd_done !== 1'b1) @(negedge clk);
        check_value({name, " frame"},
                    120'({2'b01, idx, arg, crc7(120'({2'b01, idx, arg}), 40), 1'b1}),
                    120'(last_frame));
        check_value({name, " resp_valid"}, 120'(answered), 120'(resp_valid));
        check_value({name, " timeout_err"}, 120'(rtype != RESP_NONE && fault == 2'd3),
                    120'(timeout_err));
        check_value({name, " crc_err"},
                    120'(fault == 2'd1 && en && (rtype == RESP_R1 || rtype == RESP_R2)),
                    120'(crc_err));
        check_value({name, " index_err"}, 120'(fault == 2'd2 && en && rtype == RESP_R1),
                    120'(index_err));
        check_value({name, " resp_data"},
                    !answered ? 120'd0 : (rtype == RESP_R2) ? data : 120'(arg), resp_data);
        @(negedge clk);
        check_value({name, " frame count"}, 120'(accepted), 120'(frame_count));
        check_value({name, " done count"}, 120'(accepted), 120'(dones));
    endtask

    initial begin
        rst_n          = 1'b0;
        cmd_start      = 1'b0;
        cmd_index      = '0;
        cmd_arg        = '0;
        resp_type      = RESP_NONE;
        index_check_en = 1'b0;
        crc_check_en   = 1'b0;
        silent         = 1'b1;
        reply_delay    = 2;
        reply_len      = RESP_SHORT_LEN;
        reply_frame    = '1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset status", 120'd0,
                    120'({cmd_busy, cmd_done, resp_valid, timeout_err, crc_err, index_err, cmd_oe}));
        check_value("reset cmd_o", 120'd1, 120'(cmd_o));
        check_value("reset resp_data", 120'd0, resp_data);
        for (int k = 0; k < CMD_COUNT; k++) begin
            run_cmd(k);
        end
        repeat (RESP_TIMEOUT * SD_CLK_DIV) @(negedge clk);   // Nothing may follow the last command
        check_value("final frame count", 120'(accepted), 120'(frame_count));
        check_value("final done count", 120'(accepted), 120'(dones));
        $display("No errors");
        $finish;
    end

endmodule

// File: sd_card_model.sv
module sd_card_model
    import sd_cmd_pkg::*;
(
    input  logic                     sd_clk,
    input  logic                     cmd_o,
    input  logic                     cmd_oe,
    input  logic                     silent,
    input  int                       reply_delay,   // Bit periods from end bit to start bit
    input  int                       reply_len,
    input  logic [RESP_LONG_LEN-1:0] reply_frame,   // Sent MSB first
    output logic                     cmd_i,
    output int                       frame_count,
    output logic [47:0]              last_frame
);

    logic [47:0]              shift_q;
    logic [RESP_LONG_LEN-1:0] out_sh;
    int                       rx_cnt   = 0;
    int                       frames_q = 0;
    int                       served   = 0;
    int                       wait_n   = 0;
    int                       left     = 0;
    logic                     line_q   = 1'b1;   // Line idles high

    assign cmd_i       = line_q;
    assign frame_count = frames_q;

    // Host launches on the falling edge, so the card samples on the rising one
    always @(posedge sd_clk) begin
        if (cmd_oe === 1'b1) begin
            shift_q <= {shift_q[46:0], cmd_o};
            if (rx_cnt == CMD_FRAME_LEN - 1) begin
                last_frame <= {shift_q[46:0], cmd_o};
                frames_q   <= frames_q + 1;
                rx_cnt     <= 0;
            end else begin
                rx_cnt <= rx_cnt + 1;
            end
        end else begin
            rx_cnt <= 0;
        end
    end

    always @(negedge sd_clk) begin
        if (served != frames_q) begin
            served = frames_q;            // First falling edge after the end bit
            wait_n = reply_delay - 2;
            left   = silent ? 0 : reply_len;
            out_sh = reply_frame;
        end else if (wait_n > 0) begin
            wait_n = wait_n - 1;
        end else if (left > 0) begin
            line_q <= out_sh[RESP_LONG_LEN-1];
            out_sh = {out_sh[RESP_LONG_LEN-2:0], 1'b1};
            left   = left - 1;            // Last bit sent is the end bit, line stays high
        end
    end

endmodule

// File: sd_cmd_path.sv
module sd_cmd_path
    import sd_cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_start,
    input  logic [5:0]             cmd_index,
    input  logic [31:0]            cmd_arg,
    input  logic [1:0]             resp_type,
    input  logic                   index_check_en,
    input  logic                   crc_check_en,
    input  logic                   cmd_i,
    output logic                   sd_clk,
    output logic                   cmd_o,
    output logic                   cmd_oe,
    output logic                   cmd_busy,
    output logic                   cmd_done,
    output logic                   resp_valid,
    output logic                   timeout_err,
    output logic                   crc_err,
    output logic                   index_err,
    output logic [RESP_DATA_W-1:0] resp_data
);

    logic        tx_tick;
    logic        rx_tick;
    logic        tx_start;
    logic        tx_done;
    logic [5:0]  tx_index;
    logic [31:0] tx_arg;
    logic        rx_start;
    logic        rx_done;
    logic        rx_long;
    logic        rx_crc_check;
    logic        rx_index_check;
    logic [5:0]  rx_index;
    logic        clear_status;

    sd_clk_div u_clk_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .sd_clk  (sd_clk),
        .tx_tick (tx_tick),
        .rx_tick (rx_tick)
    );

    cmd_sequencer u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_start      (cmd_start),
        .cmd_index      (cmd_index),
        .cmd_arg        (cmd_arg),
        .resp_type      (resp_type),
        .index_check_en (index_check_en),
        .crc_check_en   (crc_check_en),
        .tx_done        (tx_done),
        .rx_done        (rx_done),
        .tx_start       (tx_start),
        .tx_index       (tx_index),
        .tx_arg         (tx_arg),
        .rx_start       (rx_start),
        .rx_long        (rx_long),
        .rx_crc_check   (rx_crc_check),
        .rx_index_check (rx_index_check),
        .rx_index       (rx_index),
        .cmd_busy       (cmd_busy),
        .cmd_done       (cmd_done),
        .clear_status   (clear_status)
    );

    cmd_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_tick  (tx_tick),
        .tx_start (tx_start),
        .tx_index (tx_index),
        .tx_arg   (tx_arg),
        .cmd_o    (cmd_o),
        .cmd_oe   (cmd_oe),
        .tx_done  (tx_done)
    );

    resp_rx u_rx (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_tick        (rx_tick),
        .cmd_i          (cmd_i),
        .rx_start       (rx_start),
        .rx_long        (rx_long),
        .rx_crc_check   (rx_crc_check),
        .rx_index_check (rx_index_check),
        .rx_index       (rx_index),
        .clear_status   (clear_status),
        .rx_done        (rx_done),
        .resp_valid     (resp_valid),
        .timeout_err    (timeout_err),
        .crc_err        (crc_err),
        .index_err      (index_err),
        .resp_data      (resp_data)
    );

endmodule

// File: resp_rx.sv
module resp_rx
    import sd_cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx_tick,
    input  logic                   cmd_i,
    input  logic                   rx_start,
    input  logic                   rx_long,
    input  logic                   rx_crc_check,
    input  logic                   rx_index_check,
    input  logic [5:0]             rx_index,
    input  logic                   clear_status,
    output logic                   rx_done,
    output logic                   resp_valid,
    output logic                   timeout_err,
    output logic                   crc_err,
    output logic                   index_err,
    output logic [RESP_DATA_W-1:0] resp_data
);

    logic [RESP_LONG_LEN-3:0] sh_q;        // Bits after the start bit, end bit excluded
    logic [RX_CNT_W-1:0]      bit_cnt_q;   // Position of the bit being sampled
    logic [TO_CNT_W-1:0]      to_cnt_q;
    logic                     wait_q;
    logic                     recv_q;
    logic                     start_seen;
    logic                     last_bit;
    logic                     covered;
    logic                     crc_shift;
    logic [6:0]               crc;

    assign start_seen = wait_q && rx_tick && !cmd_i;
    assign last_bit   = rx_long ? (bit_cnt_q == RX_CNT_W'(RESP_LONG_LEN - 1))
                                : (bit_cnt_q == RX_CNT_W'(RESP_SHORT_LEN - 1));
    assign covered    = rx_long ? (bit_cnt_q >= RX_CNT_W'(LONG_HDR_LEN)
                                   && bit_cnt_q < RX_CNT_W'(LONG_HDR_LEN + RESP_DATA_W))
                                : (bit_cnt_q < RX_CNT_W'(CRC_SPAN));
    // Short frames include the start bit in the CRC
    assign crc_shift  = covered && (start_seen || (recv_q && rx_tick));

    sd_crc7 u_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (rx_start),
        .shift (crc_shift),
        .din   (cmd_i),
        .crc   (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q      <= 1'b0;
            recv_q      <= 1'b0;
            bit_cnt_q   <= '0;
            to_cnt_q    <= '0;
            rx_done     <= 1'b0;
            resp_valid  <= 1'b0;
            timeout_err <= 1'b0;
            crc_err     <= 1'b0;
            index_err   <= 1'b0;
            resp_data   <= '0;
        end else begin
            rx_done <= 1'b0;
            if (clear_status) begin
                resp_valid  <= 1'b0;
                timeout_err <= 1'b0;
                crc_err     <= 1'b0;
                index_err   <= 1'b0;
                resp_data   <= '0;
            end
            if (rx_start) begin
                wait_q    <= 1'b1;
                recv_q    <= 1'b0;
                bit_cnt_q <= '0;
                to_cnt_q  <= '0;
            end else if (start_seen) begin
                wait_q    <= 1'b0;
                recv_q    <= 1'b1;
                bit_cnt_q <= RX_CNT_W'(1);
            end else if (wait_q && rx_tick) begin
                if (to_cnt_q == TO_CNT_W'(RESP_TIMEOUT - 1)) begin
                    wait_q      <= 1'b0;   // Card stayed silent
                    rx_done     <= 1'b1;
                    timeout_err <= 1'b1;
                end else begin
                    to_cnt_q <= to_cnt_q + 1'b1;
                end
            end else if (recv_q && rx_tick) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (last_bit) begin
                    // Fields read before the end bit is shifted in
                    recv_q     <= 1'b0;
                    rx_done    <= 1'b1;
                    resp_valid <= 1'b1;
                    crc_err    <= rx_crc_check && (crc != sh_q[6:0]);
                    index_err  <= rx_index_check && (sh_q[44:39] != rx_index);
                    resp_data  <= rx_long ? sh_q[126:7] : RESP_DATA_W'(sh_q[38:7]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (recv_q && rx_tick) begin
            sh_q <= {sh_q[RESP_LONG_LEN-4:0], cmd_i};
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(resp_valid && timeout_err));

endmodule

// File: cmd_tx.sv
module cmd_tx
    import sd_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_tick,
    input  logic        tx_start,
    input  logic [5:0]  tx_index,
    input  logic [31:0] tx_arg,
    output logic        cmd_o,
    output logic        cmd_oe,
    output logic        tx_done
);

    logic [CMD_FRAME_LEN-1:0] sh_q;
    logic [TX_CNT_W-1:0]      bit_cnt_q;   // Next bit to launch
    logic                     active_q;
    logic                     launch;
    logic                     crc_phase;
    logic                     crc_shift;
    logic                     tx_bit;
    logic [6:0]               crc;

    assign launch    = active_q && tx_tick && (bit_cnt_q != TX_CNT_W'(CMD_FRAME_LEN));
    assign crc_shift = launch && (bit_cnt_q < TX_CNT_W'(CRC_SPAN));
    assign crc_phase = (bit_cnt_q >= TX_CNT_W'(CRC_SPAN))
                    && (bit_cnt_q < TX_CNT_W'(CMD_FRAME_LEN - 1));
    // CRC bits replace the zero placeholders MSB first
    assign tx_bit    = crc_phase ? crc[3'(CMD_FRAME_LEN - 2 - bit_cnt_q)]
                                 : sh_q[CMD_FRAME_LEN-1];

    sd_crc7 u_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (tx_start),
        .shift (crc_shift),
        .din   (sh_q[CMD_FRAME_LEN-1]),
        .crc   (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q  <= 1'b0;
            bit_cnt_q <= '0;
            cmd_o     <= 1'b1;
            cmd_oe    <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (tx_start) begin
                active_q  <= 1'b1;
                bit_cnt_q <= '0;
            end else if (launch) begin
                cmd_o     <= tx_bit;
                cmd_oe    <= 1'b1;
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end else if (active_q && tx_tick) begin
                active_q <= 1'b0;   // End bit period is over
                cmd_oe   <= 1'b0;
                cmd_o    <= 1'b1;
                tx_done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start) begin
            sh_q <= {1'b0, 1'b1, tx_index, tx_arg, 7'h00, 1'b1};
        end else if (launch) begin
            sh_q <= {sh_q[CMD_FRAME_LEN-2:0], 1'b1};
        end
    end

    // The line is held for exactly one frame and released together with tx_done
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_oe) |-> ##(CMD_FRAME_LEN * SD_CLK_DIV) $fell(cmd_oe) && tx_done);

endmodule

// File: cmd_sequencer.sv
module cmd_sequencer
    import sd_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_start,
    input  logic [5:0]  cmd_index,
    input  logic [31:0] cmd_arg,
    input  logic [1:0]  resp_type,
    input  logic        index_check_en,
    input  logic        crc_check_en,
    input  logic        tx_done,
    input  logic        rx_done,
    output logic        tx_start,
    output logic [5:0]  tx_index,
    output logic [31:0] tx_arg,
    output logic        rx_start,
    output logic        rx_long,
    output logic        rx_crc_check,
    output logic        rx_index_check,
    output logic [5:0]  rx_index,
    output logic        cmd_busy,
    output logic        cmd_done,
    output logic        clear_status
);

    seq_state_t state_q;
    logic       start_acc;
    logic       no_resp_q;

    assign start_acc    = (state_q == IDLE) && cmd_start;   // Starts while busy are dropped
    assign clear_status = start_acc;
    assign rx_start     = (state_q == WAIT);
    assign cmd_busy     = (state_q == SEND) || (state_q == WAIT) || (state_q == RECV);
    assign cmd_done     = (state_q == DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= IDLE;
            tx_start       <= 1'b0;
            no_resp_q      <= 1'b0;
            rx_long        <= 1'b0;
            rx_crc_check   <= 1'b0;
            rx_index_check <= 1'b0;
        end else begin
            tx_start <= start_acc;
            if (start_acc) begin
                no_resp_q      <= (resp_type == RESP_NONE);
                rx_long        <= (resp_type == RESP_R2);
                rx_crc_check   <= crc_check_en && (resp_type == RESP_R1 || resp_type == RESP_R2);
                rx_index_check <= index_check_en && (resp_type == RESP_R1);
            end
            case (state_q)
                IDLE: begin
                    if (cmd_start) begin
                        state_q <= SEND;
                    end
                end
                SEND: begin
                    if (tx_done) begin
                        state_q <= no_resp_q ? DONE : WAIT;
                    end
                end
                WAIT: state_q <= RECV;
                RECV: begin
                    if (rx_done) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_acc) begin
            tx_index <= cmd_index;
            tx_arg   <= cmd_arg;
            rx_index <= cmd_index;   // Expected echo in R1
        end
    end

    // Unit handshakes arrive only in the state that waits for them
    assert property (@(posedge clk) disable iff (!rst_n) tx_done |-> state_q == SEND);
    assert property (@(posedge clk) disable iff (!rst_n) rx_done |-> state_q == RECV);

    assert property (@(posedge clk) disable iff (!rst_n)
        start_acc |-> !$isunknown(resp_type));

endmodule

// File: sd_clk_div.sv
module sd_clk_div
    import sd_cmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic sd_clk,
    output logic tx_tick,
    output logic rx_tick
);

    logic [DIV_CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            sd_clk  <= 1'b0;
            tx_tick <= 1'b0;
            rx_tick <= 1'b0;
        end else begin
            tx_tick <= 1'b0;
            rx_tick <= 1'b0;
            if (cnt_q == DIV_CNT_W'(SD_CLK_DIV - 1)) begin
                cnt_q   <= '0;
                sd_clk  <= 1'b0;   // Falling edge, host launches
                tx_tick <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == DIV_CNT_W'(SD_CLK_DIV / 2 - 1)) begin
                    sd_clk  <= 1'b1;   // Rising edge, host samples
                    rx_tick <= 1'b1;
                end
            end
        end
    end

    // Strobes never coincide and a falling strobe follows each rising one half a period later
    assert property (@(posedge clk) disable iff (!rst_n)
        rx_tick |-> !tx_tick ##(SD_CLK_DIV / 2) tx_tick);

endmodule

// File: sd_crc7.sv
module sd_crc7 (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       shift,
    input  logic       din,
    output logic [6:0] crc
);

    logic fb;

    assign fb = din ^ crc[6];   // Feedback into taps x^3 and x^0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

// File: sd_cmd_pkg.sv
package sd_cmd_pkg;

    localparam int CMD_FRAME_LEN  = 48;   // Start, dir, index, arg, CRC7, end
    localparam int RESP_SHORT_LEN = 48;   // R1 and R3
    localparam int RESP_LONG_LEN  = 136;  // R2
    localparam int RESP_DATA_W    = 120;
    localparam int RESP_TIMEOUT   = 64;   // In SD bit periods
    localparam int SD_CLK_DIV     = 4;    // clk cycles per bit, keep even

    localparam int CRC_SPAN       = 40;   // Bits covered by CRC7 in a 48-bit frame
    localparam int LONG_HDR_LEN   = 8;    // R2 header ahead of the CRC-covered data

    // Counter widths derived from the frame sizes
    localparam int DIV_CNT_W = $clog2(SD_CLK_DIV);
    localparam int TX_CNT_W  = $clog2(CMD_FRAME_LEN + 1);
    localparam int RX_CNT_W  = $clog2(RESP_LONG_LEN);
    localparam int TO_CNT_W  = $clog2(RESP_TIMEOUT);

    localparam logic [1:0] RESP_NONE = 2'd0;
    localparam logic [1:0] RESP_R1   = 2'd1;
    localparam logic [1:0] RESP_R2   = 2'd2;
    localparam logic [1:0] RESP_R3   = 2'd3;

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT,   // One cycle to arm the receiver
        RECV,
        DONE
    } seq_state_t;

endpackage
